//--- hdl/ci_ctrl_pkg.sv
`default_nettype none

`include "ci_params.svh"

package ci_ctrl_pkg;

  // raster position inside one frame
  typedef logic [$clog2(`CI_COLS)-1:0] col_t;
  typedef logic [$clog2(`CI_ROWS)-1:0] row_t;

  // radius unit sequencing
  // FILL waits for the first row with a full neighbourhood
  // FLUSH_DONE lasts one cycle and raises the frame strobe
  typedef enum logic [1:0] {
    IDLE       = 2'd0,
    FILL       = 2'd1,
    ACTIVE     = 2'd2,
    FLUSH_DONE = 2'd3
  } unit_state_t;

endpackage

`default_nettype wire

//--- hdl/ci_line_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "ci_params.svh"

module ci_line_buffer (
  input  wire                        clk,
  input  wire                        rst_i,
  input  wire ci_pixel_pkg::pixel_t  pixel_i,
  input  wire                        pixel_valid_i,
  output ci_pixel_pkg::tap_vec_t     tap_o,
  output logic                       tap_valid_o,
  output ci_ctrl_pkg::row_t          row_o,
  output ci_ctrl_pkg::col_t          col_o
);

  import ci_pixel_pkg::*;
  import ci_ctrl_pkg::*;

  // wrap points of the raster counters
  localparam col_t LAST_COL = col_t'(`CI_COLS - 1);
  localparam row_t LAST_ROW = row_t'(`CI_ROWS - 1);

  // row memories
  // mem_q[k][c] holds the pixel k+1 rows above the live row at column c
  pixel_t mem_q [`CI_BUF_ROWS][`CI_COLS];

  // position of the pixel currently on pixel_i
  col_t col_q;
  row_t row_q;

  // tap column for the live pixel
  // tap 0 comes straight from the input
  always_comb begin
    tap_o[0] = pixel_i;
    // older rows read at the live column
    for (int k = 1; k < CI_TAPS; k++) begin
      tap_o[k] = mem_q[k-1][col_q];
    end
  end

  // taps are only meaningful while a pixel is offered
  assign tap_valid_o = pixel_valid_i;

  // position of the live pixel
  assign row_o = row_q;
  assign col_o = col_q;

  // per-column vertical shift on each accepted pixel
  // every column is touched once per row so each slot ages by one row
  always_ff @(posedge clk) begin
    if (pixel_valid_i) begin
      mem_q[0][col_q] <= pixel_i;
      for (int k = 1; k < `CI_BUF_ROWS; k++) begin
        mem_q[k][col_q] <= mem_q[k-1][col_q];
      end
    end
  end

  // raster counters
  // column runs fastest, both wrap at the frame end
  always_ff @(posedge clk) begin
    if (rst_i) begin
      col_q <= '0;
      row_q <= '0;
    end else if (pixel_valid_i) begin
      if (col_q == LAST_COL) begin
        col_q <= '0;
        // end of row
        if (row_q == LAST_ROW) begin
          // end of frame, next pixel starts a new one
          row_q <= '0;
        end else begin
          row_q <= row_q + 1'b1;
        end
      end else begin
        col_q <= col_q + 1'b1;
      end
    end
  end

  // idle cycles between pixels leave memory and counters untouched
  // so the tap column stays aligned with the raster position

endmodule

`default_nettype wire

//--- hdl/ci_pixel_pkg.sv
`default_nettype none

`include "ci_params.svh"

package ci_pixel_pkg;

  // one intensity sample
  typedef logic [`CI_PIX_W-1:0] pixel_t;

  // sum of four samples needs two extra bits
  typedef logic [`CI_PIX_W+1:0] nbr_sum_t;

  // live pixel plus the buffered rows above it
  localparam int unsigned CI_TAPS = `CI_BUF_ROWS + 1;

  // vertical column of taps, index k is k rows up
  typedef pixel_t [CI_TAPS-1:0] tap_vec_t;

endpackage

`default_nettype wire

//--- hdl/ci_radius_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "ci_params.svh"

module ci_radius_unit #(
  parameter int RADIUS = 2
) (
  input  wire                          clk,
  input  wire                          rst_i,
  input  wire ci_pixel_pkg::tap_vec_t  tap_i,
  input  wire                          tap_valid_i,
  input  wire ci_ctrl_pkg::row_t       row_i,
  input  wire ci_ctrl_pkg::col_t       col_i,
  output logic                         ci_o,
  output logic                         ci_valid_o,
  output logic                         frame_done_o
);

  import ci_pixel_pkg::*;
  import ci_ctrl_pkg::*;

  // neighbourhood spans 2r+1 rows and columns
  localparam int SPAN = 2 * RADIUS;

  // first raster position with a complete neighbourhood
  localparam row_t ROW_START = row_t'(SPAN);
  localparam col_t COL_START = col_t'(SPAN);

  // last pixel of a frame
  localparam row_t LAST_ROW = row_t'(`CI_ROWS - 1);
  localparam col_t LAST_COL = col_t'(`CI_COLS - 1);

  // horizontal window of the middle row tap
  // hwin_q[j] is that tap j accepted pixels ago
  pixel_t hwin_q [1:SPAN];

  // column delays of the bottom and top taps
  pixel_t down_dly_q [1:RADIUS];
  pixel_t up_dly_q   [1:RADIUS];

  // aligned neighbourhood around the center at (row-r, col-r)
  pixel_t center;
  pixel_t left_nb;
  pixel_t right_nb;
  pixel_t up_nb;
  pixel_t down_nb;

  nbr_sum_t nbr_sum;
  pixel_t   nbr_mean;

  logic emit;
  logic last_pix;

  unit_state_t state_q;
  unit_state_t state_d;

  // window shift, only on accepted pixels
  always_ff @(posedge clk) begin
    if (tap_valid_i) begin
      hwin_q[1] <= tap_i[RADIUS];
      for (int j = 2; j <= SPAN; j++) begin
        hwin_q[j] <= hwin_q[j-1];
      end
      down_dly_q[1] <= tap_i[0];
      up_dly_q[1]   <= tap_i[SPAN];
      for (int j = 2; j <= RADIUS; j++) begin
        down_dly_q[j] <= down_dly_q[j-1];
        up_dly_q[j]   <= up_dly_q[j-1];
      end
    end
  end

  // right neighbour is the live middle tap
  assign right_nb = tap_i[RADIUS];
  assign center   = hwin_q[RADIUS];
  assign left_nb  = hwin_q[SPAN];
  assign up_nb    = up_dly_q[RADIUS];
  assign down_nb  = down_dly_q[RADIUS];

  // axial mean, floor by dropping two bits
  assign nbr_sum = nbr_sum_t'(up_nb) + nbr_sum_t'(down_nb)
                 + nbr_sum_t'(left_nb) + nbr_sum_t'(right_nb);
  assign nbr_mean = pixel_t'(nbr_sum >> 2);

  // completing pixel of an interior center
  assign emit = tap_valid_i && (state_q == ACTIVE) && (col_i >= COL_START);

  assign last_pix = tap_valid_i && (row_i == LAST_ROW) && (col_i == LAST_COL);

  // sequencing across a frame
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (tap_valid_i) begin
          state_d = FILL;
        end
      end
      FILL: begin
        // rows above the first full neighbourhood
        if (tap_valid_i && (row_i >= ROW_START)) begin
          state_d = ACTIVE;
        end
      end
      ACTIVE: begin
        if (last_pix) begin
          state_d = FLUSH_DONE;
        end
      end
      FLUSH_DONE: begin
        // next frame may start right away
        state_d = tap_valid_i ? FILL : IDLE;
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q    <= IDLE;
      ci_valid_o <= 1'b0;
    end else begin
      state_q    <= state_d;
      ci_valid_o <= emit;
    end
  end

  // result bit, one cycle after the completing pixel
  always_ff @(posedge clk) begin
    if (emit) begin
      ci_o <= (center >= nbr_mean);
    end
  end

  // frame strobe lines up with the last result
  assign frame_done_o = (state_q == FLUSH_DONE);

endmodule

`default_nettype wire

//--- hdl/ci_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "ci_params.svh"

module ci_top (
  input  wire                        clk,
  input  wire                        rst_i,
  input  wire ci_pixel_pkg::pixel_t  pixel_i,
  input  wire                        pixel_valid_i,
  output logic                       ci_r2_o,
  output logic                       ci_valid_r2_o,
  output logic                       frame_done_r2_o,
  output logic                       ci_r4_o,
  output logic                       ci_valid_r4_o,
  output logic                       frame_done_r4_o,
  output logic                       ci_r6_o,
  output logic                       ci_valid_r6_o,
  output logic                       frame_done_r6_o
);

  import ci_pixel_pkg::*;
  import ci_ctrl_pkg::*;

  // shared tap column and raster position
  tap_vec_t taps;
  logic     tap_valid;
  row_t     row;
  col_t     col;

  // single buffer feeds all radii
  ci_line_buffer u_line_buffer (
    .clk           (clk),
    .rst_i         (rst_i),
    .pixel_i       (pixel_i),
    .pixel_valid_i (pixel_valid_i),
    .tap_o         (taps),
    .tap_valid_o   (tap_valid),
    .row_o         (row),
    .col_o         (col)
  );

  // radius 2 uses taps 0 to 4
  ci_radius_unit #(
    .RADIUS (`CI_RADIUS_A)
  ) u_ci_r2 (
    .clk          (clk),
    .rst_i        (rst_i),
    .tap_i        (taps),
    .tap_valid_i  (tap_valid),
    .row_i        (row),
    .col_i        (col),
    .ci_o         (ci_r2_o),
    .ci_valid_o   (ci_valid_r2_o),
    .frame_done_o (frame_done_r2_o)
  );

  // radius 4 uses taps 0 to 8
  ci_radius_unit #(
    .RADIUS (`CI_RADIUS_B)
  ) u_ci_r4 (
    .clk          (clk),
    .rst_i        (rst_i),
    .tap_i        (taps),
    .tap_valid_i  (tap_valid),
    .row_i        (row),
    .col_i        (col),
    .ci_o         (ci_r4_o),
    .ci_valid_o   (ci_valid_r4_o),
    .frame_done_o (frame_done_r4_o)
  );

  // radius 6 needs the whole column
  ci_radius_unit #(
    .RADIUS (`CI_RADIUS_C)
  ) u_ci_r6 (
    .clk          (clk),
    .rst_i        (rst_i),
    .tap_i        (taps),
    .tap_valid_i  (tap_valid),
    .row_i        (row),
    .col_i        (col),
    .ci_o         (ci_r6_o),
    .ci_valid_o   (ci_valid_r6_o),
    .frame_done_o (frame_done_r6_o)
  );

endmodule

`default_nettype wire

//--- include/ci_params.svh
`ifndef CI_PARAMS_SVH
`define CI_PARAMS_SVH

// image geometry in pixels
// width of one raster row
`define CI_COLS 16

// number of rows per frame
`define CI_ROWS 14

// grey level sample width
`define CI_PIX_W 8

// rows held in the line memory
// twice the largest radius so radius 6 sees 13 aligned rows
`define CI_BUF_ROWS 12

// radii served by the top level
`define CI_RADIUS_A 2
`define CI_RADIUS_B 4
`define CI_RADIUS_C 6

// largest radius must fit in the buffer
// 2 * radius rows above plus the live row

`endif

//--- run_sim.sh
#!/bin/sh
# build with Verilator from the file list, run, then look for the pass line

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --assert -Wno-fatal --top-module ci_top_tb -f verilog.f -o ci_sim \
  && ./obj_dir/ci_sim > sim.log 2>&1 \
  || { echo "build or simulation run did not complete"; cat sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -qx "all tests passed" sim.log && exit 0 || exit 1

//--- testbench/ci_patterns.hex
// lines 1 to 14: image pixels in raster order, 16 per row, 8 bits each
// then expected CI bits per center row, 10 for r2, 6 for r4, 2 for r6, leftmost center in bit 0
14 18 1c 20 24 28 2c 30 34 38 3c 40 44 48 4c 50
1c 20 24 28 2c 30 34 40 3c 40 44 48 4c 50 54 58
24 28 2c 30 34 38 3c 40 44 48 4c 50 54 58 5c 60
2c 30 34 38 3c 40 44 48 4c 50 54 58 5c 60 64 68
34 38 3c 40 44 48 4c 50 54 58 5c 5c 64 68 6c 70
3c 40 44 48 4c 50 54 58 5c 60 64 68 6c 70 74 78
6c 48 4c 50 54 58 5c 60 64 68 6c 70 74 78 7c 84
4c 50 54 58 5c 60 64 68 58 70 74 78 7c 80 84 88
54 58 5c 60 64 68 6c 70 74 78 a4 80 84 88 8c 90
5c 60 64 68 6c 70 74 78 7c 80 84 88 8c 90 94 98
64 68 6c 6f 74 78 7c 80 84 88 96 90 94 98 9c a0
6c 70 74 78 7c 80 84 88 8c 90 94 98 9c a0 a4 a8
74 78 7c 80 84 88 8c 90 94 98 9c a0 a4 a8 ac b0
7c 80 84 88 8c 90 94 98 9c a4 a4 a8 ac b0 b4 b8
fff
fdf
dff
fff
6fe
fbf
bbf
fff
bbd
f7f
3f
f7
3e
ef
fb
df
6
1

//--- testbench/ci_top_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "ci_params.svh"

module ci_top_tb;

  // pattern file layout, pixels first then expected rows per radius
  localparam int NUM_PIX   = `CI_ROWS * `CI_COLS;
  localparam int NUM_WORDS = NUM_PIX + 3 * `CI_ROWS - 24;

  localparam int NUM_FRAMES = 2;
  localparam int MAX_GAP    = 3;
  // most results any radius can give over the run
  localparam int MAX_RES    = NUM_FRAMES * (`CI_ROWS - 4) * (`CI_COLS - 4);
  // every pixel with its worst idle gap, plus reset and drain
  localparam int CYCLE_LIMIT = NUM_FRAMES * NUM_PIX * (MAX_GAP + 1) + 200;

  logic                 clk;
  logic                 rst_i;
  logic [`CI_PIX_W-1:0] pixel_i;
  logic                 pixel_valid_i;

  // index 0, 1, 2 for radius 2, 4, 6
  wire [2:0] ci;
  wire [2:0] ci_valid;
  wire [2:0] frame_done;

  logic [15:0] pat_mem [0:NUM_WORDS-1];
  logic [31:0] lfsr_q;

  // raster position of the pixel on the input
  int drv_row;
  int drv_col;
  int drv_frame;

  // input seen at the last rising edge
  logic prev_acc;
  int   prev_row;
  int   prev_col;
  int   prev_frame;

  logic res_bits [3][MAX_RES];
  int   res_cnt [3];
  int   frame_res_cnt [3][NUM_FRAMES];
  int   done_cnt [3];
  // r2, r4, r6, then anything else
  int   err_cnt [4];
  int   cycle_cnt;

  ci_top u_dut (
    .clk             (clk),
    .rst_i           (rst_i),
    .pixel_i         (pixel_i),
    .pixel_valid_i   (pixel_valid_i),
    .ci_r2_o         (ci[0]),
    .ci_valid_r2_o   (ci_valid[0]),
    .frame_done_r2_o (frame_done[0]),
    .ci_r4_o         (ci[1]),
    .ci_valid_r4_o   (ci_valid[1]),
    .frame_done_r4_o (frame_done[1]),
    .ci_r6_o         (ci[2]),
    .ci_valid_r6_o   (ci_valid[2]),
    .frame_done_r6_o (frame_done[2])
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // fibonacci LFSR, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  // two bits, one step each
  task automatic draw_gap(output int gap);
    gap = 0;
    for (int b = 0; b < 2; b++) begin
      lfsr_q = lfsr_next(lfsr_q);
      gap = gap | (int'(lfsr_q[0]) << b);
    end
  endtask

  task automatic expect_equal(input string test_name, input int idx,
                              input int expected, input int actual);
    assert (expected == actual) else begin
      $display("[ERROR] %s expected %0d actual %0d", test_name, expected, actual);
      err_cnt[idx]++;
    end
  endtask

  task automatic require(input bit cond, input string what);
    assert (cond) else begin
      $display("ERROR: %s", what);
      err_cnt[3]++;
    end
  endtask

  // first expected row of a radius inside the expected section
  function automatic int row_offset(input int idx);
    int off;
    off = 0;
    for (int j = 0; j < idx; j++) begin
      off += `CI_ROWS - 4 * (j + 1);
    end
    return off;
  endfunction

  // stored bits against expected rows, centers in raster order
  task automatic score_results();
    int r;
    int per_frame;
    int k;
    int row_w;
    int exp_bit;
    for (int i = 0; i < 3; i++) begin
      r = 2 * (i + 1);
      per_frame = (`CI_ROWS - 2 * r) * (`CI_COLS - 2 * r);
      expect_equal($sformatf("r%0d frame_done count", r), i, NUM_FRAMES, done_cnt[i]);
      k = 0;
      for (int f = 0; f < NUM_FRAMES; f++) begin
        expect_equal($sformatf("r%0d result count frame %0d", r, f), i,
                     per_frame, frame_res_cnt[i][f]);
        for (int y = 0; y < `CI_ROWS - 2 * r; y++) begin
          row_w = pat_mem[NUM_PIX + row_offset(i) + y];
          for (int x = 0; x < `CI_COLS - 2 * r; x++) begin
            exp_bit = (row_w >> x) & 1;
            if (k < res_cnt[i] && k < MAX_RES) begin
              expect_equal($sformatf("r%0d ci center (%0d,%0d) frame %0d", r, y + r, x + r, f),
                           i, exp_bit, int'(res_bits[i][k]));
            end
            k++;
          end
        end
      end
    end
  endtask

  // outputs settle after the rising edge, so look at the falling one
  always @(negedge clk) begin
    int   r;
    logic exp_valid;
    logic exp_done;
    if (!rst_i) begin
      for (int i = 0; i < 3; i++) begin
        r = 2 * (i + 1);
        // result only one cycle after a completing pixel
        exp_valid = prev_acc && (prev_row >= 2 * r) && (prev_col >= 2 * r);
        exp_done  = prev_acc && (prev_row == `CI_ROWS - 1) && (prev_col == `CI_COLS - 1);
        expect_equal($sformatf("r%0d ci_valid after (%0d,%0d)", r, prev_row, prev_col),
                     i, int'(exp_valid), int'(ci_valid[i]));
        expect_equal($sformatf("r%0d frame_done after (%0d,%0d)", r, prev_row, prev_col),
                     i, int'(exp_done), int'(frame_done[i]));
        if (frame_done[i]) begin
          done_cnt[i]++;
        end
        if (ci_valid[i]) begin
          if (res_cnt[i] < MAX_RES) begin
            res_bits[i][res_cnt[i]] = ci[i];
          end
          res_cnt[i]++;
          frame_res_cnt[i][prev_frame]++;
        end
      end
    end
    prev_acc   = pixel_valid_i;
    prev_row   = drv_row;
    prev_col   = drv_col;
    prev_frame = drv_frame;
  end

  // watchdog
  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("timeout after %0d cycles, frame strobes did not all arrive", cycle_cnt);
      $display("error counts: r2 %0d, r4 %0d, r6 %0d, other %0d",
               err_cnt[0], err_cnt[1], err_cnt[2], err_cnt[3]);
      $display("tests failed");
      $finish;
    end
  end

  initial begin
    int gap;
    int total;
    rst_i         <= 1'b1;
    pixel_i       <= '0;
    pixel_valid_i <= 1'b0;
    drv_row       <= 0;
    drv_col       <= 0;
    drv_frame     <= 0;
    prev_acc      = 1'b0;
    cycle_cnt     = 0;
    lfsr_q        = 32'h6c86_1b1c;
    $readmemh("testbench/ci_patterns.hex", pat_mem);
    require(pat_mem[0] != 16'h0 && pat_mem[NUM_WORDS-1] != 16'h0,
            "pattern file testbench/ci_patterns.hex did not load completely");

    repeat (3) @(posedge clk);
    rst_i <= 1'b0;
    @(posedge clk);

    for (int f = 0; f < NUM_FRAMES; f++) begin
      for (int p = 0; p < NUM_PIX; p++) begin
        // random idle gaps in the first frame, second one back to back
        if (f == 0) begin
          draw_gap(gap);
        end else begin
          gap = 0;
        end
        repeat (gap) begin
          pixel_valid_i <= 1'b0;
          @(posedge clk);
        end
        pixel_i       <= pat_mem[p][`CI_PIX_W-1:0];
        pixel_valid_i <= 1'b1;
        drv_row       <= p / `CI_COLS;
        drv_col       <= p % `CI_COLS;
        drv_frame     <= f;
        @(posedge clk);
      end
    end
    pixel_valid_i <= 1'b0;

    // wait for every radius to close both frames
    while (done_cnt[0] < NUM_FRAMES || done_cnt[1] < NUM_FRAMES
           || done_cnt[2] < NUM_FRAMES) begin
      @(posedge clk);
    end
    // late strobes would still show up here
    repeat (8) @(posedge clk);

    score_results();
    total = err_cnt[0] + err_cnt[1] + err_cnt[2] + err_cnt[3];
    $display("error counts: r2 %0d, r4 %0d, r6 %0d, other %0d",
             err_cnt[0], err_cnt[1], err_cnt[2], err_cnt[3]);
    if (total == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+include
hdl/ci_pixel_pkg.sv
hdl/ci_ctrl_pkg.sv
hdl/ci_line_buffer.sv
hdl/ci_radius_unit.sv
hdl/ci_top.sv
testbench/ci_top_tb.sv
